/* dv/pwr_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwr_defines.svh"

module pwr_ctrl_tb
    import pwr_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 1000;

    logic                   clk;
    logic                   rstn;
    logic                   req_valid;
    logic                   req_write;
    logic [`PWR_ADDR_W-1:0] req_addr;
    logic [`PWR_DATA_W-1:0] req_wdata;
    logic                   req_ready;
    logic [`PWR_DATA_W-1:0] rdata;
    logic                   rvalid;
    logic                   cluster_busy;
    logic                   wakeup_event;
    logic                   power_down;
    logic                   clock_enable;
    logic                   cluster_rstn;

    // current pattern record
    int fd;
    int nread;
    int rec_idx;
    int kind;
    int busy_cyc;
    int rst_cyc;
    int pol;
    int busy_hold;
    int exp_width;
    logic [8*160-1:0] line;
    string test_name;
    logic seq_done;

    pwr_tb_clk clk_gen_inst (.clk_o(clk));

    pwr_ctrl_top pwr_ctrl_top_inst
    (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .req_valid_i    (req_valid),
        .req_write_i    (req_write),
        .req_addr_i     (req_addr),
        .req_wdata_i    (req_wdata),
        .req_ready_o    (req_ready),
        .rdata_o        (rdata),
        .rvalid_o       (rvalid),
        .cluster_busy_i (cluster_busy),
        .wakeup_event_i (wakeup_event),
        .power_down_o   (power_down),
        .clock_enable_o (clock_enable),
        .cluster_rstn_o (cluster_rstn)
    );

    task automatic abort_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        abort_run();
    endtask

    function automatic logic sample_output(input int sel);
        return (sel == 0) ? cluster_rstn : power_down; // 0 selects the cluster reset
    endfunction

    // counts the negedges seen before the output reaches the level
    task automatic wait_level(input string what, input int sel, input logic level,
                              output int cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (sample_output(sel) !== level)
        begin
            n++;
            if (n > TIMEOUT_CYCLES)
                report_timeout(what);
            @(negedge clk);
        end
        cycles = n;
    endtask

    task automatic reg_write(input string name, input logic [`PWR_ADDR_W-1:0] addr,
                             input logic [`PWR_DATA_W-1:0] data, output int stall_cycles);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= 1'b1;
        req_addr  <= addr;
        req_wdata <= data;
        @(negedge clk);
        while (!req_ready)
        begin
            n++;
            if (n > TIMEOUT_CYCLES)
                report_timeout({name, " to be accepted"});
            @(negedge clk);
        end
        @(posedge clk); // transfer happens on this edge
        req_valid <= 1'b0;
        req_write <= 1'b0;
        stall_cycles = n;
    endtask

    task automatic reg_read(input string name, input logic [`PWR_ADDR_W-1:0] addr,
                            input logic [`PWR_DATA_W-1:0] expected);
        int n;
        n = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req_write <= 1'b0;
        req_addr  <= addr;
        req_wdata <= '0;
        @(negedge clk);
        while (!req_ready)
        begin
            n++;
            if (n > TIMEOUT_CYCLES)
                report_timeout({name, " to be accepted"});
            @(negedge clk);
        end
        check_value({name, " rvalid before accept"}, 0, rvalid);
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        check_value({name, " rvalid"}, 1, rvalid);
        check_value(name, expected, rdata);
        @(negedge clk);
        check_value({name, " rvalid single cycle"}, 0, rvalid);
    endtask

    // entered at the first negedge with the cluster in reset
    task automatic measure_rst_low(output int width);
        int n;
        n = 0;
        while (cluster_rstn === 1'b0)
        begin
            check_value({test_name, " power_down_o in reset"}, 0, power_down);
            n++;
            if (n > TIMEOUT_CYCLES)
                report_timeout({test_name, " cluster_rstn_o to rise"});
            @(negedge clk);
        end
        width = n;
    endtask

    task automatic configure();
        int stalls;
        reg_write({test_name, " busy cfg"}, `PWR_REG_BUSY_CYC, 16'(busy_cyc), stalls);
        reg_write({test_name, " rst cfg"}, `PWR_REG_RST_CYC, 16'(rst_cyc), stalls);
        reg_write({test_name, " pol cfg"}, `PWR_REG_WAKE_POL, 16'(pol), stalls);
        reg_read({test_name, " busy readback"}, `PWR_REG_BUSY_CYC, 16'(busy_cyc));
        reg_read({test_name, " rst readback"}, `PWR_REG_RST_CYC, 16'(rst_cyc));
        reg_read({test_name, " pol readback"}, `PWR_REG_WAKE_POL, 16'(pol));
    endtask

    task automatic run_sw_reset();
        int stalls;
        int delay;
        int width;
        configure();
        reg_write({test_name, " reset cmd"}, `PWR_REG_CMD, 16'h0001, stalls);
        wait_level({test_name, " cluster_rstn_o to fall"}, 0, 1'b0, delay);
        // the request pulse cycle plus a quiet count of busy cycles + 1
        check_value({test_name, " quiet delay"}, busy_cyc + 2, delay);
        measure_rst_low(width);
        check_value({test_name, " reset width"}, exp_width, width);
        reg_read({test_name, " status"}, `PWR_REG_STATUS, IDLE);
    endtask

    task automatic run_busy_holdoff();
        int stalls;
        int delay;
        int width;
        int i;
        @(posedge clk);
        cluster_busy <= 1'b1;
        configure();
        reg_write({test_name, " reset cmd"}, `PWR_REG_CMD, 16'h0001, stalls);
        seq_done = 1'b0;
        fork
            begin
                for (i = 0; i < busy_hold; i++)
                begin
                    @(negedge clk);
                    check_value({test_name, " rstn while busy"}, 1, cluster_rstn);
                end
                @(posedge clk);
                cluster_busy <= 1'b0;
                wait_level({test_name, " cluster_rstn_o to fall"}, 0, 1'b0, delay);
                // two synchronizer stages plus the quiet count
                check_value({test_name, " quiet delay"}, 1, delay >= busy_cyc + 3);
                measure_rst_low(width);
                check_value({test_name, " reset width"}, exp_width, width);
                seq_done = 1'b1;
            end
            begin
                reg_write({test_name, " blocked cmd"}, `PWR_REG_CMD, 16'h0000, stalls);
                check_value({test_name, " cmd stalled"}, 1, stalls > 0);
                check_value({test_name, " cmd after sequence"}, 1, seq_done);
            end
        join
        reg_read({test_name, " status"}, `PWR_REG_STATUS, IDLE);
    endtask

    task automatic run_power_down();
        int stalls;
        int delay;
        int width;
        logic wake_act;
        wake_act = (pol != 0);
        configure();
        @(posedge clk);
        wakeup_event <= ~wake_act;
        reg_write({test_name, " power-down cmd"}, `PWR_REG_CMD, 16'h0002, stalls);
        wait_level({test_name, " power_down_o to rise"}, 1, 1'b1, delay);
        check_value({test_name, " power-down delay"}, busy_cyc + 2, delay);
        check_value({test_name, " clock gated"}, 0, clock_enable);
        check_value({test_name, " rstn while off"}, 0, cluster_rstn);
        reg_read({test_name, " status off"}, `PWR_REG_STATUS, OFF);
        check_value({test_name, " clock still gated"}, 0, clock_enable);
        @(posedge clk);
        wakeup_event <= wake_act;
        @(negedge clk);
        check_value({test_name, " clock on wakeup"}, 1, clock_enable);
        check_value({test_name, " power_down_o on wakeup"}, 1, power_down);
        wait_level({test_name, " power_down_o to fall"}, 1, 1'b0, delay);
        measure_rst_low(width);
        check_value({test_name, " reset width"}, exp_width, width);
        @(posedge clk);
        wakeup_event <= ~wake_act;
        reg_read({test_name, " status"}, `PWR_REG_STATUS, IDLE);
    endtask

    task automatic run_record();
        test_name = $sformatf("record %0d kind %0d", rec_idx, kind);
        case (kind)
            0: run_sw_reset();
            1: run_busy_holdoff();
            2: run_power_down();
            default:
            begin
                $display("unknown test kind %0d in record %0d", kind, rec_idx);
                abort_run();
            end
        endcase
    endtask

    initial
    begin
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        cluster_busy = 1'b0;
        wakeup_event = 1'b0;
        seq_done     = 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        @(negedge clk);
        test_name = "reset";
        check_value("reset power_down_o", 0, power_down);
        check_value("reset cluster_rstn_o", 1, cluster_rstn);
        check_value("reset clock_enable_o", 1, clock_enable);
        check_value("reset req_ready_o", 1, req_ready);
        reg_read("reset busy cycles", `PWR_REG_BUSY_CYC, 16'd4);
        reg_read("reset rst cycles", `PWR_REG_RST_CYC, 16'd8);
        reg_read("reset polarity", `PWR_REG_WAKE_POL, 16'd1);
        reg_read("reset status", `PWR_REG_STATUS, IDLE);

        fd = $fopen("dv/pwr_patterns.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the pattern file dv/pwr_patterns.txt");
            abort_run();
        end
        rec_idx = 0;
        while (!$feof(fd))
        begin
            nread = $fscanf(fd, " %d %d %d %d %d %d", kind, busy_cyc, rst_cyc, pol,
                            busy_hold, exp_width);
            if (nread == 6)
            begin
                rec_idx++;
                run_record();
            end
            else
            begin
                nread = $fgets(line, fd); // skips a comment line
            end
        end
        $fclose(fd);
        check_value("pattern records found", 1, rec_idx > 0);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/pwr_patterns.txt */
# kind: 0 software reset, 1 busy hold-off, 2 power-down with wakeup
# kind busy_cycles rst_cycles wake_polarity busy_hold expected_rst_width
0 4 8 1 0 9
0 0 0 1 0 1
0 2 5 1 0 6
0 7 1 0 0 2
1 3 4 1 10 5
1 0 2 1 5 3
1 6 0 1 20 1
1 1 9 0 3 10
2 4 8 1 0 9
2 0 3 0 0 4
2 2 0 1 0 1
2 5 6 0 0 7
0 15 12 0 0 13
1 10 3 1 7 4
2 9 2 1 0 3

/* dv/pwr_tb_clk.sv */
`timescale 1ns/1ps
`default_nettype none

module pwr_tb_clk
#(
    parameter real PERIOD_NS = 8.0
)
(
    output logic clk_o
);

    initial
    begin
        clk_o = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+src
src/pwr_pkg.sv
src/pwr_sync.sv
src/pwr_cycle_counter.sv
src/power_manager.sv
src/pwr_cfg_regs.sv
src/pwr_ctrl_top.sv
dv/pwr_tb_clk.sv
dv/pwr_ctrl_tb.sv

/* src/power_manager.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwr_defines.svh"

module power_manager
    import pwr_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  power_down_req_i,
    input  logic                  cluster_rst_req_i,
    input  logic                  cluster_busy_i,
    input  logic                  wakeup_event_i,
    input  logic                  cfg_wakeup_polarity_i,
    input  logic [`PWR_CNT_W-1:0] cfg_busy_cycle_i,
    input  logic [`PWR_CNT_W-1:0] cfg_rst_cycle_i,
    output logic                  power_down_o,
    output logic                  clock_enable_o,
    output logic                  cluster_rstn_o,
    output pwr_state_t            state_o
);

    pwr_state_t state_q;
    pwr_state_t state_d;
    pwr_req_t   req_type_q;
    pwr_req_t   req_type_d;

    logic busy_sync;
    logic wakeup_adj;
    logic wakeup_sync;
    logic busy_cnt_clear;
    logic busy_cnt_event;
    logic rst_cnt_clear;
    logic rst_cnt_event;
    logic clk_off;

    assign wakeup_adj = cfg_wakeup_polarity_i ? wakeup_event_i : ~wakeup_event_i;

    // busy is assumed until the pin has been sampled
    pwr_sync #(.RESET_VAL(1'b1)) busy_sync_inst
    (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .d_i    (cluster_busy_i),
        .q_o    (busy_sync)
    );

    pwr_sync #(.RESET_VAL(1'b0)) wakeup_sync_inst
    (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .d_i    (wakeup_adj),
        .q_o    (wakeup_sync)
    );

    pwr_cycle_counter busy_counter
    (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .cfg_i   (cfg_busy_cycle_i),
        .clear_i (busy_cnt_clear),
        .event_o (busy_cnt_event)
    );

    pwr_cycle_counter rst_counter
    (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .cfg_i   (cfg_rst_cycle_i),
        .clear_i (rst_cnt_clear),
        .event_o (rst_cnt_event)
    );

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            state_q    <= IDLE;
            req_type_q <= REQ_SW_RST;
        end
        else
        begin
            state_q    <= state_d;
            req_type_q <= req_type_d;
        end
    end

    always_comb
    begin
        state_d        = state_q;
        req_type_d     = req_type_q;
        power_down_o   = 1'b0;
        cluster_rstn_o = 1'b1;
        busy_cnt_clear = 1'b1;
        rst_cnt_clear  = 1'b1;
        clk_off        = 1'b0;

        case (state_q)
            IDLE:
            begin
                if (power_down_req_i || cluster_rst_req_i)
                begin
                    state_d    = WAIT_NO_BUSY;
                    req_type_d = power_down_req_i ? REQ_POWER_DOWN : REQ_SW_RST;
                end
            end
            WAIT_NO_BUSY:
            begin
                busy_cnt_clear = busy_sync; // any busy cycle restarts the quiet count
                if (busy_cnt_event)
                begin
                    state_d = (req_type_q == REQ_POWER_DOWN) ? OFF : CLUSTER_RST;
                end
            end
            OFF:
            begin
                power_down_o   = 1'b1;
                cluster_rstn_o = 1'b0;
                clk_off        = 1'b1;
                if (wakeup_sync)
                begin
                    state_d = CLUSTER_RST;
                end
            end
            CLUSTER_RST:
            begin
                cluster_rstn_o = 1'b0;
                rst_cnt_clear  = 1'b0;
                if (rst_cnt_event)
                begin
                    state_d = IDLE;
                end
            end
            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    // the raw pin bypasses the synchronizer so the cluster clock returns at once
    assign clock_enable_o = ~clk_off | wakeup_adj;
    assign state_o        = state_q;

    // leaving power-down always goes through the counted reset
    a_pd_holds_rst: assert property (@(posedge clk_i) disable iff (!rstn_i)
        power_down_o |=> !cluster_rstn_o);

    // the cluster is only acted on while the synchronized busy is low
    a_quiet_before_act: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (state_q == WAIT_NO_BUSY) && (state_d != WAIT_NO_BUSY) |-> !busy_sync);

endmodule

`default_nettype wire

/* src/pwr_cfg_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwr_defines.svh"

module pwr_cfg_regs
    import pwr_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  logic [`PWR_ADDR_W-1:0] req_addr_i,
    input  logic [`PWR_DATA_W-1:0] req_wdata_i,
    output logic                   req_ready_o,
    output logic [`PWR_DATA_W-1:0] rdata_o,
    output logic                   rvalid_o,
    input  pwr_state_t             state_i,
    output logic [`PWR_CNT_W-1:0]  cfg_busy_cycle_o,
    output logic [`PWR_CNT_W-1:0]  cfg_rst_cycle_o,
    output logic                   cfg_wakeup_polarity_o,
    output logic                   power_down_req_o,
    output logic                   cluster_rst_req_o
);

    localparam logic [`PWR_CNT_W-1:0] BUSY_CYC_RST = 4;
    localparam logic [`PWR_CNT_W-1:0] RST_CYC_RST  = 8;

    logic                   cmd_write;
    logic                   accept;
    logic                   req_pending;
    logic [`PWR_DATA_W-1:0] rdata_d;

    assign cmd_write   = req_write_i && (req_addr_i == `PWR_REG_CMD);
    // a pulse still in flight counts as busy, the state only moves a cycle later
    assign req_pending = power_down_req_o | cluster_rst_req_o;
    assign req_ready_o = ~(cmd_write && ((state_i != IDLE) || req_pending));
    assign accept      = req_valid_i & req_ready_o;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cfg_busy_cycle_o      <= BUSY_CYC_RST;
            cfg_rst_cycle_o       <= RST_CYC_RST;
            cfg_wakeup_polarity_o <= 1'b1;
        end
        else if (accept && req_write_i)
        begin
            case (req_addr_i)
                `PWR_REG_BUSY_CYC: cfg_busy_cycle_o      <= req_wdata_i[`PWR_CNT_W-1:0];
                `PWR_REG_RST_CYC:  cfg_rst_cycle_o       <= req_wdata_i[`PWR_CNT_W-1:0];
                `PWR_REG_WAKE_POL: cfg_wakeup_polarity_o <= req_wdata_i[0];
                default:           ;
            endcase
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            power_down_req_o  <= 1'b0;
            cluster_rst_req_o <= 1'b0;
        end
        else
        begin
            power_down_req_o  <= accept && cmd_write && req_wdata_i[1];
            cluster_rst_req_o <= accept && cmd_write && req_wdata_i[0] && !req_wdata_i[1];
        end
    end

    always_comb
    begin
        case (req_addr_i)
            `PWR_REG_BUSY_CYC:
                rdata_d = {{(`PWR_DATA_W-`PWR_CNT_W){1'b0}}, cfg_busy_cycle_o};
            `PWR_REG_RST_CYC:
                rdata_d = {{(`PWR_DATA_W-`PWR_CNT_W){1'b0}}, cfg_rst_cycle_o};
            `PWR_REG_WAKE_POL:
                rdata_d = {{(`PWR_DATA_W-1){1'b0}}, cfg_wakeup_polarity_o};
            `PWR_REG_STATUS:
                rdata_d = {{(`PWR_DATA_W-$bits(pwr_state_t)){1'b0}}, state_i};
            default:
                rdata_d = '0; // the command register reads as zero
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            rvalid_o <= 1'b0;
        end
        else
        begin
            rvalid_o <= accept && !req_write_i;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (accept && !req_write_i)
        begin
            rdata_o <= rdata_d;
        end
    end

    // the sequencer only honours requests in IDLE
    a_req_in_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (power_down_req_o || cluster_rst_req_o) |-> (state_i == IDLE));

endmodule

`default_nettype wire

/* src/pwr_ctrl_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwr_defines.svh"

module pwr_ctrl_top
    import pwr_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  logic                   req_valid_i,
    input  logic                   req_write_i,
    input  logic [`PWR_ADDR_W-1:0] req_addr_i,
    input  logic [`PWR_DATA_W-1:0] req_wdata_i,
    output logic                   req_ready_o,
    output logic [`PWR_DATA_W-1:0] rdata_o,
    output logic                   rvalid_o,
    input  logic                   cluster_busy_i,
    input  logic                   wakeup_event_i,
    output logic                   power_down_o,
    output logic                   clock_enable_o,
    output logic                   cluster_rstn_o
);

    logic [`PWR_CNT_W-1:0] cfg_busy_cycle;
    logic [`PWR_CNT_W-1:0] cfg_rst_cycle;
    logic                  cfg_wakeup_polarity;
    logic                  power_down_req;
    logic                  cluster_rst_req;
    pwr_state_t            state;

    pwr_cfg_regs pwr_cfg_regs_inst
    (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .req_valid_i           (req_valid_i),
        .req_write_i           (req_write_i),
        .req_addr_i            (req_addr_i),
        .req_wdata_i           (req_wdata_i),
        .req_ready_o           (req_ready_o),
        .rdata_o               (rdata_o),
        .rvalid_o              (rvalid_o),
        .state_i               (state),
        .cfg_busy_cycle_o      (cfg_busy_cycle),
        .cfg_rst_cycle_o       (cfg_rst_cycle),
        .cfg_wakeup_polarity_o (cfg_wakeup_polarity),
        .power_down_req_o      (power_down_req),
        .cluster_rst_req_o     (cluster_rst_req)
    );

    power_manager power_manager_inst
    (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .power_down_req_i      (power_down_req),
        .cluster_rst_req_i     (cluster_rst_req),
        .cluster_busy_i        (cluster_busy_i),
        .wakeup_event_i        (wakeup_event_i),
        .cfg_wakeup_polarity_i (cfg_wakeup_polarity),
        .cfg_busy_cycle_i      (cfg_busy_cycle),
        .cfg_rst_cycle_i       (cfg_rst_cycle),
        .power_down_o          (power_down_o),
        .clock_enable_o        (clock_enable_o),
        .cluster_rstn_o        (cluster_rstn_o),
        .state_o               (state)
    );

endmodule

`default_nettype wire

/* src/pwr_cycle_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pwr_defines.svh"

module pwr_cycle_counter
(
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic [`PWR_CNT_W-1:0] cfg_i,
    input  logic                  clear_i,
    output logic                  event_o
);

    logic [`PWR_CNT_W-1:0] count_q;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            count_q <= '0;
        end
        else if (clear_i)
        begin
            count_q <= '0;
        end
        else if (count_q < cfg_i)
        begin
            count_q <= count_q + 1'b1; // holds at cfg_i once reached
        end
    end

    // the register still holds the old count in the first cleared cycle
    assign event_o = ~clear_i & (count_q == cfg_i);

    // a running count never passes the configured value, else the event would be lost
    a_count_saturates: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !clear_i |-> (count_q <= cfg_i));

endmodule

`default_nettype wire

/* src/pwr_defines.svh */
`ifndef PWR_DEFINES_SVH
`define PWR_DEFINES_SVH

// width of the busy and reset cycle counts
`define PWR_CNT_W 10

// register port
`define PWR_ADDR_W 3
`define PWR_DATA_W 16

// register map
`define PWR_REG_BUSY_CYC 3'd0
`define PWR_REG_RST_CYC  3'd1
`define PWR_REG_WAKE_POL 3'd2
`define PWR_REG_CMD      3'd3 // bit 1 power-down, bit 0 reset
`define PWR_REG_STATUS   3'd4 // sequencer state in the low bits

`endif

/* src/pwr_pkg.sv */
`default_nettype none

package pwr_pkg;

    // sequencer states, also reported through the status register
    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_NO_BUSY,
        OFF,
        CLUSTER_RST
    } pwr_state_t;

    // kind of request latched when leaving IDLE
    typedef enum logic
    {
        REQ_SW_RST,
        REQ_POWER_DOWN
    } pwr_req_t;

endpackage

`default_nettype wire

/* src/pwr_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module pwr_sync
#(
    parameter logic RESET_VAL = 1'b0
)
(
    input  logic clk_i,
    input  logic rstn_i,
    input  logic d_i,
    output logic q_o
);

    logic meta_q;
    logic sync_q;

    // both stages start at the same value so no edge is seen out of reset
    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            meta_q <= RESET_VAL;
            sync_q <= RESET_VAL;
        end
        else
        begin
            meta_q <= d_i;
            sync_q <= meta_q;
        end
    end

    assign q_o = sync_q;

endmodule

`default_nettype wire
